//--- alu_exec_top.f
+incdir+verilog
+incdir+testbench
verilog/alu_pkg.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/alu_issue_queue.sv
verilog/alu_exec_stage.sv
verilog/alu_exec_top.sv
testbench/tb_alu_exec_top.sv

//--- Bender.yml
package:
  name: alu_exec_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/alu_pkg.sv
      - verilog/int_alu.sv
      - verilog/branch_unit.sv
      - verilog/alu_issue_queue.sv
      - verilog/alu_exec_stage.sv
      - verilog/alu_exec_top.sv
  - target: test
    include_dirs:
      - verilog
      - testbench
    files:
      - testbench/tb_alu_exec_top.sv

//--- testbench/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer ops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic xlen_t int_result(issue_bundle_t b);
    xlen_t                     op2;
    logic [$clog2(`XLEN)-1:0] shamt;
    xlen_t                     res;
    op2   = b.immv ? b.imm : b.rs2_data;
    shamt = op2[$clog2(`XLEN)-1:0];
    case (b.op)
        `INT_ADD: res = b.rs1_data + op2;
        `INT_LUI: res = b.imm;
        `INT_SLT: begin
            if (b.sext) begin
                res = xlen_t'($signed(b.rs1_data) < $signed(op2));
            end else begin
                res = xlen_t'(b.rs1_data < op2);
            end
        end
        `INT_XOR: res = b.rs1_data ^ op2;
        `INT_AND: res = b.rs1_data & op2;
        `INT_SL:  res = b.rs1_data << shamt;
        `INT_SRL: res = b.rs1_data >> shamt;
        `INT_SRA: res = xlen_t'($signed(b.rs1_data) >>> shamt);
        default:  res = '0;
    endcase
    return res;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic logic branch_taken(issue_bundle_t b);
    logic lt;
    if (b.sext) begin
        lt = $signed(b.rs1_data) < $signed(b.rs2_data);
    end else begin
        lt = b.rs1_data < b.rs2_data;
    end
    case (branch_op_t'(b.op))
        `BRANCH_BEQ: return b.rs1_data == b.rs2_data;
        `BRANCH_BNE: return b.rs1_data != b.rs2_data;
        `BRANCH_BLT: return lt;
        `BRANCH_BGE: return !lt;
        default:     return 1'b0;
    endcase
endfunction

function automatic vaddr_t jump_target(issue_bundle_t b);
    return vaddr_t'(b.rs1_data + b.imm);
endfunction

// word after this slot counted from the aligned block start
function automatic xlen_t link_address(issue_bundle_t b);
    vaddr_t base;
    base = {b.stream.start_addr[`VADDR_SIZE-1:2], 2'b00};
    return xlen_t'(base + vaddr_t'(b.offset) * 4 + 4);
endfunction

function automatic logic mispredicted(issue_bundle_t b);
    if (!b.is_branch) begin
        return 1'b0;
    end
    case (branch_op_t'(b.op))
        `BRANCH_JALR: return b.stream.target != jump_target(b);
        `BRANCH_JAL:  return 1'b0;
        default: begin
            if (b.offset == b.stream.size) begin
                return branch_taken(b) != b.stream.taken;
            end
            return branch_taken(b);
        end
    endcase
endfunction

function automatic xlen_t writeback_result(issue_bundle_t b);
    return b.is_branch ? link_address(b) : int_result(b);
endfunction

`endif

//--- testbench/tb_alu_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module tb_alu_exec_top;
    import alu_pkg::*;

    `include "alu_ref_model.svh"

    localparam int RANDOM_BUNDLES = 400;
    localparam int FILL_BUNDLES   = 200;
    localparam int TOTAL_BUNDLES  = RANDOM_BUNDLES + FILL_BUNDLES;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BUNDLES + 100;

    typedef struct packed {
        issue_bundle_t bundle;
        xlen_t         result;
        logic [31:0]   due;
    } pending_t;

    logic          clk;
    logic          rst_n;
    logic          issue_valid;
    issue_bundle_t issue;
    logic          issue_ready;
    logic          wb_valid;
    wb_bundle_t    wb;
    logic          redirect_valid;
    redirect_t     redirect;

    pending_t exp_q[$];
    rob_idx_t next_rob;
    int       cycle;
    int       queued;
    int       last_due;
    int       accepted_total;
    int       checks;
    int       errors;

    alu_exec_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .wb_valid       (wb_valid),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("MISMATCH %s at cycle %0d: expected %0h, actual %0h",
                     name, cycle, expected, actual);
        end
    endtask

    task automatic confirm(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at cycle %0d: %s", cycle, what);
        end
    endtask

    function automatic issue_bundle_t random_bundle(rob_idx_t rob);
        issue_bundle_t b;
        b                   = '0;
        b.is_branch         = ($urandom % 4) == 0;
        b.immv              = 1'($urandom % 2);
        b.sext              = 1'($urandom % 2);
        b.op                = b.is_branch ? int_op_t'($urandom % 6) : int_op_t'($urandom % 9);
        b.imm               = $urandom;
        b.rs1_data          = $urandom;
        b.rs2_data          = (($urandom % 4) == 0) ? b.rs1_data : xlen_t'($urandom);
        b.offset            = pred_offset_t'($urandom);
        b.stream.start_addr = $urandom;
        b.stream.size       = pred_offset_t'($urandom);
        b.stream.taken      = 1'($urandom % 2);
        b.stream.target     = $urandom;
        b.rob_idx           = rob;
        // half the time the prediction is the true outcome
        if (($urandom % 2) == 0) begin
            b.stream.size   = b.offset;
            b.stream.taken  = branch_taken(b);
            b.stream.target = jump_target(b);
        end
        return b;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        cycle++;
    endtask

    task automatic drive_next();
        if (accepted_total >= TOTAL_BUNDLES) begin
            issue_valid <= 1'b0;
        end else begin
            issue <= random_bundle(next_rob);
            next_rob++;
            issue_valid <= (accepted_total >= RANDOM_BUNDLES) ? 1'b1 : 1'($urandom % 2);
        end
    endtask

    task automatic score_writeback();
        pending_t head;
        if (wb_valid) begin
            if (exp_q.size() == 0) begin
                confirm(1'b0, "writeback with no bundle pending");
            end else begin
                head = exp_q.pop_front();
                compare_value("wb.rob_idx", head.bundle.rob_idx, wb.rob_idx);
                compare_value("wb.result", head.result, wb.result);
                compare_value("writeback cycle", head.due, cycle);
                compare_value("redirect_valid", mispredicted(head.bundle), redirect_valid);
                if (redirect_valid) begin
                    compare_value("redirect.rob_idx", head.bundle.rob_idx, redirect.rob_idx);
                    compare_value("redirect.target", jump_target(head.bundle), redirect.target);
                end
            end
        end else begin
            confirm(!redirect_valid, "redirect raised without a writeback");
            if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                confirm(1'b0, "pending bundle never wrote back");
                void'(exp_q.pop_front());
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one clock edge with outputs seen as they were before it
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_cycle();
        pending_t entry;
        logic     accepted;
        logic     hold;
        next_edge();
        accepted = issue_valid && issue_ready;
        hold     = issue_valid && !issue_ready;
        compare_value("issue_ready", queued < `QUEUE_DEPTH, issue_ready);
        score_writeback();
        if (redirect_valid) begin
            // whole queue goes along with this edge's accept
            exp_q.delete();
            queued   = 0;
            last_due = cycle;
        end else begin
            queued = queued - int'(queued > 0);
            if (accepted) begin
                entry.bundle = issue;
                entry.result = writeback_result(issue);
                entry.due    = (cycle + 2 > last_due + 1) ? cycle + 2 : last_due + 1;
                last_due     = entry.due;
                exp_q.push_back(entry);
                queued++;
            end
        end
        if (accepted) begin
            accepted_total++;
        end
        if (!hold) begin
            drive_next();
        end
    endtask

    initial begin
        void'($urandom(32'hc587_52b4));
        rst_n          = 1'b0;
        issue_valid    = 1'b0;
        issue          = '0;
        next_rob       = '0;
        cycle          = 0;
        queued         = 0;
        last_due       = 0;
        accepted_total = 0;
        checks         = 0;
        errors         = 0;
        repeat (4) next_edge();
        confirm(!wb_valid && !redirect_valid, "valid outputs high in reset");
        confirm(issue_ready, "issue_ready low after reset");
        rst_n <= 1'b1;
        drive_next();
        while (accepted_total < TOTAL_BUNDLES || exp_q.size() != 0) begin
            run_cycle();
        end
        repeat (4) run_cycle();
        $display("checks: %0d  errors: %0d  accepted: %0d", checks, errors, accepted_total);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d  errors: %0d  accepted: %0d", checks, errors, accepted_total);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/alu_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  alu_pkg::issue_bundle_t issue,
    output logic                  issue_ready,
    output logic                  wb_valid,
    output alu_pkg::wb_bundle_t    wb,
    output logic                  redirect_valid,
    output alu_pkg::redirect_t     redirect
);
    import alu_pkg::*;

    logic          disp_valid;
    issue_bundle_t disp;

    // a redirect flushes everything still waiting
    alu_issue_queue alu_issue_queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .flush       (redirect_valid),
        .issue_ready (issue_ready),
        .disp_valid  (disp_valid),
        .disp        (disp)
    );

    alu_exec_stage alu_exec_stage_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .disp_valid     (disp_valid),
        .disp           (disp),
        .flush          (redirect_valid),
        .wb_valid       (wb_valid),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

endmodule

`default_nettype wire

//--- verilog/alu_exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  disp_valid,
    input  alu_pkg::issue_bundle_t disp,
    input  logic                  flush,
    output logic                  wb_valid,
    output alu_pkg::wb_bundle_t    wb,
    output logic                  redirect_valid,
    output alu_pkg::redirect_t     redirect
);
    import alu_pkg::*;

    xlen_t  alu_result;
    xlen_t  br_result;
    vaddr_t br_target;
    logic   br_error;
    logic   exec_valid;

    int_alu int_alu_i (
        .immv     (disp.immv),
        .sext     (disp.sext),
        .op       (disp.op),
        .imm      (disp.imm),
        .rs1_data (disp.rs1_data),
        .rs2_data (disp.rs2_data),
        .result   (alu_result)
    );

    branch_unit branch_unit_i (
        .sext       (disp.sext),
        .op         (branch_op_t'(disp.op)),
        .imm        (disp.imm),
        .rs1_data   (disp.rs1_data),
        .rs2_data   (disp.rs2_data),
        .stream     (disp.stream),
        .offset     (disp.offset),
        .taken      (),
        .pred_error (br_error),
        .target     (br_target),
        .result     (br_result)
    );

    assign exec_valid = disp_valid && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= exec_valid;
            redirect_valid <= exec_valid && disp.is_branch && br_error;
        end
    end

    always_ff @(posedge clk) begin
        wb.rob_idx       <= disp.rob_idx;
        wb.result        <= disp.is_branch ? br_result : alu_result;
        redirect.rob_idx <= disp.rob_idx;
        redirect.target  <= br_target;
    end

endmodule

`default_nettype wire

//--- verilog/alu_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_issue_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  alu_pkg::issue_bundle_t issue,
    input  logic                  flush,
    output logic                  issue_ready,
    output logic                  disp_valid,
    output alu_pkg::issue_bundle_t disp
);
    import alu_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    issue_bundle_t    entries [`QUEUE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign issue_ready = count < (PTR_W+1)'(`QUEUE_DEPTH);
    assign disp_valid  = (count != '0) && !flush;
    assign disp        = entries[head];

    // anything arriving with a flush is dropped
    assign push = issue_valid && issue_ready && !flush;
    assign pop  = disp_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(`QUEUE_DEPTH-1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(`QUEUE_DEPTH-1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= issue;
        end
    end

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module branch_unit (
    input  logic                  sext,
    input  alu_pkg::branch_op_t    op,
    input  alu_pkg::xlen_t        imm,
    input  alu_pkg::xlen_t        rs1_data,
    input  alu_pkg::xlen_t        rs2_data,
    input  alu_pkg::fetch_stream_t stream,
    input  alu_pkg::pred_offset_t  offset,
    output logic                  taken,
    output logic                  pred_error,
    output alu_pkg::vaddr_t       target,
    output alu_pkg::xlen_t        result
);
    import alu_pkg::*;

    logic                      equal;
    logic                      ult;
    logic                      slt;
    logic                      lt;
    logic [`PREDICTION_WIDTH:0] addr_offset;
    logic [`VADDR_SIZE-3:0]    link_word;
    logic                      stream_hit;

    // condition always compares the two registers
    assign equal = rs1_data == rs2_data;
    assign ult   = rs1_data < rs2_data;
    assign slt   = (rs1_data[`XLEN-1] != rs2_data[`XLEN-1]) ? rs1_data[`XLEN-1] : ult;
    assign lt    = sext ? slt : ult;

    always_comb begin
        case (op)
            `BRANCH_BEQ: taken = equal;
            `BRANCH_BNE: taken = ~equal;
            `BRANCH_BLT: taken = lt;
            `BRANCH_BGE: taken = ~lt;
            default:     taken = 1'b0;
        endcase
    end

    assign target = vaddr_t'(rs1_data + imm);

    // link is the word after this slot in the fetch block
    assign addr_offset = offset + 1'b1;
    assign link_word   = stream.start_addr[`VADDR_SIZE-1:2] + (`VADDR_SIZE-2)'(addr_offset);
    assign result      = xlen_t'({link_word, 2'b00});

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // prediction check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign stream_hit = stream.size == offset;

    always_comb begin
        if (op == `BRANCH_JALR) begin
            pred_error = stream.target != target;
        end else if (op == `BRANCH_JAL) begin
            pred_error = 1'b0;
        end else if (stream_hit) begin
            pred_error = taken ^ stream.taken;
        end else begin
            // block predicted to run past this slot
            pred_error = taken;
        end
    end

endmodule

`default_nettype wire

//--- verilog/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module int_alu (
    input  logic            immv,
    input  logic            sext,
    input  alu_pkg::int_op_t op,
    input  alu_pkg::xlen_t  imm,
    input  alu_pkg::xlen_t  rs1_data,
    input  alu_pkg::xlen_t  rs2_data,
    output alu_pkg::xlen_t  result
);
    import alu_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    xlen_t              data1;
    xlen_t              data2;
    xlen_t              add_result;
    logic [SHAMT_W-1:0] shamt;
    logic               ult;
    logic               slt;
    logic               lt;

    assign data1      = rs1_data;
    assign data2      = immv ? imm : rs2_data;
    assign add_result = data1 + data2;
    assign shamt      = data2[SHAMT_W-1:0];

    // signed less-than from the sign bits and the unsigned compare
    assign ult = data1 < data2;
    assign slt = (data1[`XLEN-1] != data2[`XLEN-1]) ? data1[`XLEN-1] : ult;
    assign lt  = sext ? slt : ult;

    always_comb begin
        case (op)
            `INT_ADD: begin
                result = add_result;
            end
            `INT_LUI: begin
                result = imm;
            end
            `INT_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lt};
            end
            `INT_XOR: begin
                result = data1 ^ data2;
            end
            `INT_AND: begin
                result = data1 & data2;
            end
            `INT_SL: begin
                result = data1 << shamt;
            end
            `INT_SRL: begin
                result = data1 >> shamt;
            end
            `INT_SRA: begin
                result = xlen_t'($signed(data1) >>> shamt);
            end
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/alu_pkg.sv
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

    typedef logic [`XLEN-1:0]             xlen_t;
    typedef logic [`VADDR_SIZE-1:0]       vaddr_t;
    typedef logic [`INTOP_WIDTH-1:0]      int_op_t;
    typedef logic [`BRANCHOP_WIDTH-1:0]   branch_op_t;
    typedef logic [`PREDICTION_WIDTH-1:0] pred_offset_t;
    typedef logic [`ROB_IDX_WIDTH-1:0]    rob_idx_t;

    // prediction made by fetch for the whole block
    typedef struct packed {
        vaddr_t       start_addr;
        pred_offset_t size;
        logic         taken;
        vaddr_t       target;
    } fetch_stream_t;

    // the branch unit reads the shared op as a branch op
    typedef struct packed {
        logic          is_branch;
        logic          immv;
        logic          sext;
        int_op_t       op;
        xlen_t         imm;
        xlen_t         rs1_data;
        xlen_t         rs2_data;
        fetch_stream_t stream;
        pred_offset_t  offset;
        rob_idx_t      rob_idx;
    } issue_bundle_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        xlen_t    result;
    } wb_bundle_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        vaddr_t   target;
    } redirect_t;

endpackage

`default_nettype wire

//--- verilog/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XLEN             32
`define VADDR_SIZE       32
`define PREDICTION_WIDTH 3
`define INTOP_WIDTH      4
`define BRANCHOP_WIDTH   4
`define ROB_IDX_WIDTH    6

// entries in the issue queue
`define QUEUE_DEPTH      4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer op codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define INT_ADD          4'd0
`define INT_LUI          4'd1
`define INT_SLT          4'd2
`define INT_XOR          4'd3
`define INT_AND          4'd4
`define INT_SL           4'd5
`define INT_SRL          4'd6
`define INT_SRA          4'd7

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch op codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BRANCH_BEQ       4'd0
`define BRANCH_BNE       4'd1
`define BRANCH_BLT       4'd2
`define BRANCH_BGE       4'd3
`define BRANCH_JAL       4'd4
`define BRANCH_JALR      4'd5

`endif
